/* source/mips_pkg.sv */
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_sltu,
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_t;

    // fetch_wait is where reset parks the core before the first fetch
    typedef enum logic [2:0] {
        st_fetch,
        st_fetch_wait,
        st_decode,
        st_execute,
        st_mem_read,
        st_mem_write,
        st_writeback,
        st_halted
    } cpu_state_t;

    // primary opcodes
    localparam opcode_t op_rtype = 6'h00;
    localparam opcode_t op_j     = 6'h02;
    localparam opcode_t op_jal   = 6'h03;
    localparam opcode_t op_beq   = 6'h04;
    localparam opcode_t op_bne   = 6'h05;
    localparam opcode_t op_addiu = 6'h09;
    localparam opcode_t op_sltiu = 6'h0b;
    localparam opcode_t op_andi  = 6'h0c;
    localparam opcode_t op_ori   = 6'h0d;
    localparam opcode_t op_xori  = 6'h0e;
    localparam opcode_t op_lui   = 6'h0f;
    localparam opcode_t op_lw    = 6'h23;
    localparam opcode_t op_sw    = 6'h2b;

    // r-type function field
    localparam funct_t fn_sll  = 6'h00;
    localparam funct_t fn_srl  = 6'h02;
    localparam funct_t fn_jr   = 6'h08;
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_xor  = 6'h26;
    localparam funct_t fn_sltu = 6'h2b;

    // datapath select encodings
    localparam logic [1:0] pc_seq    = 2'd0;
    localparam logic [1:0] pc_branch = 2'd1;
    localparam logic [1:0] pc_jump   = 2'd2;
    localparam logic [1:0] pc_reg    = 2'd3;
    localparam logic [1:0] dest_rt   = 2'd0;
    localparam logic [1:0] dest_rd   = 2'd1;
    localparam logic [1:0] dest_r31  = 2'd2;
    localparam logic [1:0] wb_alu    = 2'd0;
    localparam logic [1:0] wb_mem    = 2'd1;
    localparam logic [1:0] wb_link   = 2'd2;

endpackage

/* source/mips_ctrl_if.sv */
`timescale 1ns/1ps

interface mips_ctrl_if;
    import mips_pkg::*;

    // control to datapath
    logic       ir_write;
    logic       pc_write;
    logic [1:0] pc_src;
    logic       alu_src_a;
    logic       alu_src_b;
    alu_op_t    alu_op;
    logic       imm_zero_ext;
    logic       reg_write;
    logic [1:0] reg_dest;
    logic [1:0] reg_data_sel;
    logic       a_b_load;
    logic       alu_out_load;
    logic       mdr_load;
    logic       iord;

    // datapath to control
    opcode_t    opcode;
    funct_t     funct;
    logic       alu_zero;
    logic       pc_is_zero;

    modport control (
        output ir_write, pc_write, pc_src, alu_src_a, alu_src_b, alu_op, imm_zero_ext,
        output reg_write, reg_dest, reg_data_sel, a_b_load, alu_out_load, mdr_load, iord,
        input  opcode, funct, alu_zero, pc_is_zero
    );

    modport datapath (
        input  ir_write, pc_write, pc_src, alu_src_a, alu_src_b, alu_op, imm_zero_ext,
        input  reg_write, reg_dest, reg_data_sel, a_b_load, alu_out_load, mdr_load, iord,
        output opcode, funct, alu_zero, pc_is_zero
    );

endinterface

/* source/mips_alu.sv */
`timescale 1ns/1ps

module mips_alu (
    input  mips_pkg::word_t   a,
    input  mips_pkg::word_t   b,
    input  logic [4:0]        shamt,
    input  mips_pkg::alu_op_t op,
    output mips_pkg::word_t   result,
    output logic              zero
);
    import mips_pkg::*;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_xor:  result = a ^ b;
            // unsigned compare, also used by sltiu
            alu_sltu: result = {31'b0, (a < b)};
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_lui:  result = {b[15:0], 16'h0000};
            default:  result = '0;
        endcase
    end

    // beq/bne look at this with sub selected
    assign zero = (result == '0);

endmodule

/* source/mips_regfile.sv */
`timescale 1ns/1ps

module mips_regfile (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::reg_idx_t read_a,
    input  mips_pkg::reg_idx_t read_b,
    input  mips_pkg::reg_idx_t write_idx,
    input  mips_pkg::word_t    write_data,
    input  logic               write_en,
    output mips_pkg::word_t    data_a,
    output mips_pkg::word_t    data_b,
    output mips_pkg::word_t    v0
);
    import mips_pkg::*;

    // r0 has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en && write_idx != '0) begin
            regs[write_idx] <= write_data;
        end
    end

    assign data_a = (read_a == '0) ? '0 : regs[read_a];
    assign data_b = (read_b == '0) ? '0 : regs[read_b];
    assign v0     = regs[2];

    // a write aimed at r0 must not show up on the next read of r0
    a_r0_zero: assert property (@(posedge clk) disable iff (rst)
        (write_en && write_idx == '0) |=> (read_a != '0 || data_a == '0)
                                          && (read_b != '0 || data_b == '0));

endmodule

/* source/mips_datapath.sv */
`timescale 1ns/1ps

module mips_datapath #(
    parameter mips_pkg::word_t reset_vector = 32'hBFC0_0000
) (
    input  logic            clk,
    input  logic            rst,
    input  mips_pkg::word_t readdata,
    output mips_pkg::word_t address,
    output mips_pkg::word_t writedata,
    output mips_pkg::word_t register_v0,
    mips_ctrl_if.datapath   ctrl
);
    import mips_pkg::*;

    word_t    pc;
    word_t    ir;
    word_t    mdr;
    word_t    reg_a;
    word_t    reg_b;
    word_t    alu_out;
    word_t    pc_next;
    word_t    imm_ext;
    word_t    branch_target;
    word_t    jump_target;
    word_t    alu_in_a;
    word_t    alu_in_b;
    word_t    alu_result;
    word_t    rf_data_a;
    word_t    rf_data_b;
    word_t    rf_write_data;
    reg_idx_t rf_write_idx;

    assign imm_ext = ctrl.imm_zero_ext ? {16'h0000, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

    // pc already holds pc+4 once the instruction is in ir
    assign branch_target = pc + {imm_ext[29:0], 2'b00};
    assign jump_target   = {pc[31:28], ir[25:0], 2'b00};

    always_comb begin
        case (ctrl.pc_src)
            pc_seq:    pc_next = pc + 32'd4;
            pc_branch: pc_next = branch_target;
            pc_jump:   pc_next = jump_target;
            default:   pc_next = reg_a;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_vector;
        end else if (ctrl.pc_write) begin
            pc <= pc_next;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write) begin
            ir <= readdata;
        end
        if (ctrl.mdr_load) begin
            mdr <= readdata;
        end
        if (ctrl.a_b_load) begin
            reg_a <= rf_data_a;
            reg_b <= rf_data_b;
        end
        if (ctrl.alu_out_load) begin
            alu_out <= alu_result;
        end
    end

    // shifts take rt on the a side
    assign alu_in_a = ctrl.alu_src_a ? reg_b : reg_a;
    assign alu_in_b = ctrl.alu_src_b ? imm_ext : reg_b;

    always_comb begin
        case (ctrl.reg_dest)
            dest_rt: rf_write_idx = ir[20:16];
            dest_rd: rf_write_idx = ir[15:11];
            default: rf_write_idx = 5'd31;
        endcase
        case (ctrl.reg_data_sel)
            wb_alu:  rf_write_data = alu_out;
            wb_mem:  rf_write_data = mdr;
            default: rf_write_data = pc;
        endcase
    end

    mips_regfile regfile_inst (
        .clk        (clk),
        .rst        (rst),
        .read_a     (ir[25:21]),
        .read_b     (ir[20:16]),
        .write_idx  (rf_write_idx),
        .write_data (rf_write_data),
        .write_en   (ctrl.reg_write),
        .data_a     (rf_data_a),
        .data_b     (rf_data_b),
        .v0         (register_v0)
    );

    mips_alu alu_inst (
        .a      (alu_in_a),
        .b      (alu_in_b),
        .shamt  (ir[10:6]),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .zero   (ctrl.alu_zero)
    );

    assign address         = ctrl.iord ? alu_out : pc;
    assign writedata       = reg_b;
    assign ctrl.opcode     = ir[31:26];
    assign ctrl.funct      = ir[5:0];
    assign ctrl.pc_is_zero = (reg_a == '0);

    a_pc_aligned: assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00);

endmodule

/* source/mips_control.sv */
`timescale 1ns/1ps

module mips_control (
    input  logic         clk,
    input  logic         rst,
    input  logic         waitrequest,
    output logic         read,
    output logic         write,
    output logic         active,
    mips_ctrl_if.control ctrl
);
    import mips_pkg::*;

    cpu_state_t state;
    cpu_state_t state_next;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_fetch_wait;
        end else begin
            state <= state_next;
        end
    end

    // alu setup depends only on the instruction
    always_comb begin
        ctrl.alu_op       = alu_add;
        ctrl.alu_src_a    = 1'b0;
        ctrl.alu_src_b    = 1'b1;
        ctrl.imm_zero_ext = 1'b0;
        case (ctrl.opcode)
            op_rtype: begin
                ctrl.alu_src_b = 1'b0;
                case (ctrl.funct)
                    fn_subu: ctrl.alu_op = alu_sub;
                    fn_and:  ctrl.alu_op = alu_and;
                    fn_or:   ctrl.alu_op = alu_or;
                    fn_xor:  ctrl.alu_op = alu_xor;
                    fn_sltu: ctrl.alu_op = alu_sltu;
                    fn_sll: begin
                        ctrl.alu_op    = alu_sll;
                        ctrl.alu_src_a = 1'b1;
                    end
                    fn_srl: begin
                        ctrl.alu_op    = alu_srl;
                        ctrl.alu_src_a = 1'b1;
                    end
                    default: ctrl.alu_op = alu_add;
                endcase
            end
            op_beq, op_bne: begin
                ctrl.alu_op    = alu_sub;
                ctrl.alu_src_b = 1'b0;
            end
            op_sltiu: ctrl.alu_op = alu_sltu;
            op_andi: begin
                ctrl.alu_op       = alu_and;
                ctrl.imm_zero_ext = 1'b1;
            end
            op_ori: begin
                ctrl.alu_op       = alu_or;
                ctrl.imm_zero_ext = 1'b1;
            end
            op_xori: begin
                ctrl.alu_op       = alu_xor;
                ctrl.imm_zero_ext = 1'b1;
            end
            op_lui:  ctrl.alu_op = alu_lui;
            default: ctrl.alu_op = alu_add;
        endcase
    end

    always_comb begin
        state_next        = state;
        read              = 1'b0;
        write             = 1'b0;
        active            = 1'b1;
        ctrl.ir_write     = 1'b0;
        ctrl.pc_write     = 1'b0;
        ctrl.pc_src       = pc_seq;
        ctrl.reg_write    = 1'b0;
        ctrl.reg_dest     = dest_rt;
        ctrl.reg_data_sel = wb_alu;
        ctrl.a_b_load     = 1'b0;
        ctrl.alu_out_load = 1'b0;
        ctrl.mdr_load     = 1'b0;
        ctrl.iord         = 1'b0;
        case (state)
            st_fetch_wait: state_next = st_fetch;
            st_fetch: begin
                read = 1'b1;
                if (!waitrequest) begin
                    ctrl.ir_write = 1'b1;
                    ctrl.pc_write = 1'b1;
                    state_next    = st_decode;
                end
            end
            st_decode: begin
                ctrl.a_b_load = 1'b1;
                state_next    = st_execute;
            end
            st_execute: begin
                ctrl.alu_out_load = 1'b1;
                state_next        = st_writeback;
                case (ctrl.opcode)
                    op_rtype: begin
                        if (ctrl.funct == fn_jr) begin
                            ctrl.pc_src   = pc_reg;
                            ctrl.pc_write = !ctrl.pc_is_zero;
                            state_next    = ctrl.pc_is_zero ? st_halted : st_fetch;
                        end
                    end
                    op_beq: begin
                        ctrl.pc_src   = pc_branch;
                        ctrl.pc_write = ctrl.alu_zero;
                        state_next    = st_fetch;
                    end
                    op_bne: begin
                        ctrl.pc_src   = pc_branch;
                        ctrl.pc_write = !ctrl.alu_zero;
                        state_next    = st_fetch;
                    end
                    op_j, op_jal: begin
                        ctrl.pc_src       = pc_jump;
                        ctrl.pc_write     = 1'b1;
                        // link is the pc before the jump lands, already pc+4
                        ctrl.reg_write    = (ctrl.opcode == op_jal);
                        ctrl.reg_dest     = dest_r31;
                        ctrl.reg_data_sel = wb_link;
                        state_next        = st_fetch;
                    end
                    op_lw:   state_next = st_mem_read;
                    op_sw:   state_next = st_mem_write;
                    default: state_next = st_writeback;
                endcase
            end
            st_mem_read: begin
                read      = 1'b1;
                ctrl.iord = 1'b1;
                if (!waitrequest) begin
                    ctrl.mdr_load = 1'b1;
                    state_next    = st_writeback;
                end
            end
            st_mem_write: begin
                write     = 1'b1;
                ctrl.iord = 1'b1;
                if (!waitrequest) begin
                    state_next = st_fetch;
                end
            end
            st_writeback: begin
                ctrl.reg_write    = 1'b1;
                ctrl.reg_dest     = (ctrl.opcode == op_rtype) ? dest_rd : dest_rt;
                ctrl.reg_data_sel = (ctrl.opcode == op_lw) ? wb_mem : wb_alu;
                state_next        = st_fetch;
            end
            st_halted: active = 1'b0;
            default:   state_next = st_fetch_wait;
        endcase
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (rst) !(read && write));

    // once halted, nothing leaves the core until reset
    a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
        state == st_halted |=> state == st_halted && !read && !write);

endmodule

/* source/mips_cpu_bus.sv */
`timescale 1ns/1ps

module mips_cpu_bus #(
    parameter mips_pkg::word_t reset_vector = 32'hBFC0_0000
) (
    input  logic            clk,
    input  logic            rst,
    output logic            active,
    output mips_pkg::word_t register_v0,

    // avalon master
    output mips_pkg::word_t address,
    output logic            write,
    output logic            read,
    input  logic            waitrequest,
    output mips_pkg::word_t writedata,
    output logic [3:0]      byteenable,
    input  mips_pkg::word_t readdata
);

    mips_ctrl_if ctrl_bus ();

    mips_control control_inst (
        .clk         (clk),
        .rst         (rst),
        .waitrequest (waitrequest),
        .read        (read),
        .write       (write),
        .active      (active),
        .ctrl        (ctrl_bus.control)
    );

    mips_datapath #(
        .reset_vector (reset_vector)
    ) datapath_inst (
        .clk         (clk),
        .rst         (rst),
        .readdata    (readdata),
        .address     (address),
        .writedata   (writedata),
        .register_v0 (register_v0),
        .ctrl        (ctrl_bus.datapath)
    );

    // word accesses only
    assign byteenable = 4'b1111;

endmodule

/* sim/avalon_mem_model.sv */
`timescale 1ns/1ps

module avalon_mem_model #(
    parameter mips_pkg::word_t prog_base = 32'hBFC0_0000,
    parameter mips_pkg::word_t data_base = 32'h0000_1000
) (
    input  logic            clk,
    input  logic            stretch_en,
    input  mips_pkg::word_t address,
    input  logic            read,
    input  logic            write,
    input  mips_pkg::word_t writedata,
    output logic            waitrequest,
    output mips_pkg::word_t readdata
);
    import mips_pkg::*;

    word_t prog [0:1023];
    word_t data [0:63];

    word_t      rng_state = 32'h14df_4c0c;
    logic [1:0] wait_left = 2'd0;
    word_t      rng_next;
    logic       in_prog;
    logic       in_data;

    function automatic word_t lcg_next(input word_t s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    assign in_prog = (address[31:12] == prog_base[31:12]);
    assign in_data = (address[31:8] == data_base[31:8]);
    assign rng_next = lcg_next(rng_state);

    // unmapped space returns a pattern of the address itself
    always_comb begin
        if (in_prog) begin
            readdata = prog[address[11:2]];
        end else if (in_data) begin
            readdata = data[address[7:2]];
        end else begin
            readdata = address ^ 32'h5a5a_0f0f;
        end
    end

    assign waitrequest = (wait_left != 2'd0);

    // each transfer completes on the edge where wait_left is zero
    always @(posedge clk) begin
        if (read || write) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 2'd1;
            end else begin
                if (write && in_prog) begin
                    prog[address[11:2]] <= writedata;
                end else if (write && in_data) begin
                    data[address[7:2]] <= writedata;
                end
                rng_state <= rng_next;
                wait_left <= stretch_en ? rng_next[17:16] : 2'd0;
            end
        end
    end

endmodule

/* sim/tb_mips_cpu_bus.sv */
`timescale 1ns/1ps

module tb_mips_cpu_bus;
    import mips_pkg::*;

    localparam word_t reset_vector = 32'hBFC0_0000;
    localparam word_t data_base    = 32'h0000_1000;
    localparam int    cycle_limit  = 20000;

    logic       clk;
    logic       rst;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       write;
    logic       read;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;
    logic       stretch_en;

    int    errors = 0;
    int    tests_passed = 0;
    int    tests_failed = 0;
    int    cycle_count = 0;
    word_t code [$];

    logic  prev_rd = 1'b0;
    logic  prev_wr = 1'b0;
    logic  prev_wait = 1'b0;
    word_t prev_addr = '0;
    word_t prev_wdata = '0;

    mips_cpu_bus #(
        .reset_vector (reset_vector)
    ) mips_cpu_bus_inst (
        .clk         (clk),
        .rst         (rst),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .write       (write),
        .read        (read),
        .waitrequest (waitrequest),
        .writedata   (writedata),
        .byteenable  (byteenable),
        .readdata    (readdata)
    );

    avalon_mem_model #(
        .prog_base (reset_vector),
        .data_base (data_base)
    ) mem_inst (
        .clk         (clk),
        .stretch_en  (stretch_en),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // bus protocol monitor and run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the CPU did not finish within %0d cycles", cycle_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end else begin
            if (!rst) begin
                if (read && write) begin
                    $display("Error at %0t: read and write are high together", $time);
                    errors++;
                end
                if ((prev_rd || prev_wr) && prev_wait
                    && (read != prev_rd || write != prev_wr || address != prev_addr
                        || (prev_wr && writedata != prev_wdata))) begin
                    $display("Error at %0t: bus request changed while waitrequest was high",
                             $time);
                    errors++;
                end
                // word accesses only
                if ((read || write) && byteenable !== 4'b1111) begin
                    $display("Fail at %0t ns: byteenable expected %h, got %h", $time,
                             4'b1111, byteenable);
                    errors++;
                end
            end
            prev_rd    <= read;
            prev_wr    <= write;
            prev_wait  <= waitrequest;
            prev_addr  <= address;
            prev_wdata <= writedata;
        end
    end

    function automatic word_t r_type(funct_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd,
                                     logic [4:0] shamt);
        return {op_rtype, rs, rt, rd, shamt, fn};
    endfunction

    function automatic word_t i_type(opcode_t op, reg_idx_t rs, reg_idx_t rt,
                                     logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t j_type(opcode_t op, word_t target);
        return {op, target[27:2]};
    endfunction

    function automatic word_t halt_instr();
        return r_type(fn_jr, 5'd0, 5'd0, 5'd0, 5'd0);
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (expected !== actual) begin
            $display("Fail at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic load_code();
        for (int i = 0; i < 1024; i++) begin
            mem_inst.prog[i] = (reset_vector + 4 * i) ^ 32'h5a5a_0f0f;
        end
        for (int i = 0; i < 64; i++) begin
            mem_inst.data[i] = (data_base + 4 * i) ^ 32'h5a5a_0f0f;
        end
        foreach (code[i]) begin
            mem_inst.prog[i] = code[i];
        end
        code.delete();
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        #1 rst = 1'b1;
        repeat (10) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic wait_halt();
        while (active) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    task automatic test_alu();
        int    e0;
        word_t a;
        word_t m;
        word_t b;
        word_t expected;
        e0 = errors;
        a  = 32'd100;
        m  = 32'hFFFF_FFFD;
        b  = 32'h1234_5678;
        code.push_back(i_type(op_addiu, 5'd0, 5'd8, 16'd100));
        code.push_back(i_type(op_addiu, 5'd0, 5'd12, 16'hFFFD));
        code.push_back(i_type(op_lui, 5'd0, 5'd9, 16'h1234));
        code.push_back(i_type(op_ori, 5'd9, 5'd9, 16'h5678));
        code.push_back(r_type(fn_addu, 5'd8, 5'd9, 5'd10, 5'd0));
        code.push_back(r_type(fn_subu, 5'd8, 5'd9, 5'd11, 5'd0));
        code.push_back(r_type(fn_and, 5'd9, 5'd12, 5'd13, 5'd0));
        code.push_back(r_type(fn_or, 5'd8, 5'd12, 5'd14, 5'd0));
        code.push_back(r_type(fn_xor, 5'd9, 5'd12, 5'd15, 5'd0));
        code.push_back(r_type(fn_sltu, 5'd8, 5'd9, 5'd16, 5'd0));
        code.push_back(r_type(fn_sltu, 5'd9, 5'd8, 5'd17, 5'd0));
        code.push_back(i_type(op_sltiu, 5'd12, 5'd18, 16'd5));
        code.push_back(i_type(op_sltiu, 5'd8, 5'd19, 16'hFFFF));
        code.push_back(r_type(fn_sll, 5'd0, 5'd9, 5'd20, 5'd4));
        code.push_back(r_type(fn_srl, 5'd0, 5'd12, 5'd21, 5'd28));
        code.push_back(i_type(op_andi, 5'd9, 5'd22, 16'hF0F0));
        code.push_back(i_type(op_xori, 5'd8, 5'd23, 16'h00FF));
        // r0 must stay zero
        code.push_back(i_type(op_addiu, 5'd0, 5'd0, 16'd5));
        code.push_back(r_type(fn_addu, 5'd0, 5'd10, 5'd2, 5'd0));
        for (int r = 11; r <= 23; r++) begin
            code.push_back(r_type(fn_addu, 5'd2, reg_idx_t'(r), 5'd2, 5'd0));
        end
        code.push_back(r_type(fn_addu, 5'd2, 5'd0, 5'd2, 5'd0));
        code.push_back(halt_instr());
        load_code();
        pulse_reset();
        wait_halt();
        expected = (a + b) + (a - b) + m + (b & m) + (a | m) + (b ^ m)
                 + {31'b0, a < b} + {31'b0, b < a} + {31'b0, m < 32'd5}
                 + {31'b0, a < 32'hFFFF_FFFF} + (b << 4) + (m >> 28)
                 + (b & 32'h0000_F0F0) + (a ^ 32'h0000_00FF);
        check_word("register_v0", expected, register_v0);
        report_test("alu", e0);
    endtask

    task automatic test_load_store();
        int e0;
        e0 = errors;
        code.push_back(i_type(op_addiu, 5'd0, 5'd8, 16'h1000));
        code.push_back(i_type(op_lui, 5'd0, 5'd9, 16'hCAFE));
        code.push_back(i_type(op_ori, 5'd9, 5'd9, 16'hBABE));
        code.push_back(i_type(op_sw, 5'd8, 5'd9, 16'd0));
        code.push_back(i_type(op_addiu, 5'd0, 5'd10, 16'd77));
        code.push_back(i_type(op_sw, 5'd8, 5'd10, 16'd4));
        code.push_back(i_type(op_lw, 5'd8, 5'd11, 16'd0));
        code.push_back(i_type(op_lw, 5'd8, 5'd12, 16'd4));
        code.push_back(r_type(fn_addu, 5'd11, 5'd12, 5'd2, 5'd0));
        code.push_back(halt_instr());
        load_code();
        pulse_reset();
        wait_halt();
        check_word("register_v0", 32'hCAFE_BABE + 32'd77, register_v0);
        check_word("mem data[0]", 32'hCAFE_BABE, mem_inst.data[0]);
        check_word("mem data[1]", 32'd77, mem_inst.data[1]);
        report_test("load_store", e0);
    endtask

    task automatic test_branches(input string name);
        int    e0;
        word_t sum;
        e0  = errors;
        sum = '0;
        for (int i = 1; i <= 10; i++) begin
            sum = sum + i;
        end
        code.push_back(i_type(op_addiu, 5'd0, 5'd9, 16'd1));
        code.push_back(i_type(op_addiu, 5'd0, 5'd10, 16'd11));
        code.push_back(r_type(fn_addu, 5'd2, 5'd9, 5'd2, 5'd0));
        code.push_back(i_type(op_addiu, 5'd9, 5'd9, 16'd1));
        code.push_back(i_type(op_bne, 5'd9, 5'd10, 16'hFFFD));
        code.push_back(i_type(op_beq, 5'd0, 5'd0, 16'd1));
        code.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd1000));
        // both of these fall through
        code.push_back(i_type(op_beq, 5'd2, 5'd0, 16'd1));
        code.push_back(i_type(op_addiu, 5'd0, 5'd11, 16'd7));
        code.push_back(i_type(op_bne, 5'd0, 5'd0, 16'd1));
        code.push_back(i_type(op_addiu, 5'd11, 5'd11, 16'd1));
        code.push_back(i_type(op_addiu, 5'd0, 5'd12, 16'h1000));
        code.push_back(i_type(op_sw, 5'd12, 5'd11, 16'd0));
        code.push_back(halt_instr());
        load_code();
        pulse_reset();
        wait_halt();
        check_word("register_v0", sum, register_v0);
        check_word("mem data[0]", 32'd8, mem_inst.data[0]);
        report_test(name, e0);
    endtask

    task automatic test_jumps();
        int e0;
        e0 = errors;
        code.push_back(i_type(op_addiu, 5'd0, 5'd2, 16'd5));
        code.push_back(j_type(op_j, reset_vector + 32'd12));
        code.push_back(i_type(op_addiu, 5'd0, 5'd2, 16'd99));
        code.push_back(j_type(op_jal, reset_vector + 32'd24));
        code.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd10));
        code.push_back(halt_instr());
        code.push_back(i_type(op_addiu, 5'd2, 5'd2, 16'd1));
        code.push_back(r_type(fn_jr, 5'd31, 5'd0, 5'd0, 5'd0));
        load_code();
        pulse_reset();
        wait_halt();
        check_word("register_v0", 32'd16, register_v0);
        // the bus must stay quiet once halted
        for (int i = 0; i < 50; i++) begin
            @(posedge clk);
            #1;
            if (read || write || active) begin
                $display("Error at %0t: bus activity or active high after halt", $time);
                errors++;
            end
        end
        report_test("jumps", e0);
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        code.push_back(halt_instr());
        load_code();
        pulse_reset();
        check_word("read", 32'd0, {31'b0, read});
        check_word("write", 32'd0, {31'b0, write});
        check_word("active", 32'd1, {31'b0, active});
        while (!read) begin
            @(posedge clk);
            #1;
        end
        check_word("address", reset_vector, address);
        wait_halt();
        report_test("reset", e0);
    endtask

    initial begin
        rst        = 1'b1;
        stretch_en = 1'b0;
        test_reset();
        test_alu();
        test_load_store();
        test_branches("branches");
        test_jumps();
        stretch_en = 1'b1;
        test_branches("wait_states");
        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* all.f */
source/mips_pkg.sv
source/mips_ctrl_if.sv
source/mips_alu.sv
source/mips_regfile.sv
source/mips_datapath.sv
source/mips_control.sv
source/mips_cpu_bus.sv
sim/avalon_mem_model.sv
sim/tb_mips_cpu_bus.sv
